// File: verilog/cnn_geom_pkg.sv
package cnn_geom_pkg;

  localparam int WORD_W      = 32; // bram data and address
  localparam int PIX_W       = 8;  // pixel, weight and result byte
  localparam int KSIZE       = 5;
  localparam int KTAPS       = 25; // KSIZE * KSIZE
  localparam int NUM_PE      = 8;  // one pe per output channel
  localparam int TILE_COLS   = 8;
  localparam int TILE_ROWS   = 6;
  localparam int IF_WORDS    = 12;
  localparam int W_WORDS     = 50;
  localparam int QUANT_SHIFT = 2;
  localparam int ACC_W       = 24;
  localparam int POOL_POS    = 4;  // conv positions per 2x2 pool window
  localparam int WORD_BYTES  = WORD_W / PIX_W;

  // tap i+5*j is row j, column i of the window
  typedef struct packed {
    logic [KTAPS-1:0][PIX_W-1:0] pix;
  } window_t;

  // same tap order as window_t, two's complement
  typedef struct packed {
    logic [KTAPS-1:0][PIX_W-1:0] w;
  } kernel_t;

  // lower channel sits in the top byte
  typedef struct packed {
    logic [PIX_W-1:0] b0;
    logic [PIX_W-1:0] b1;
    logic [PIX_W-1:0] b2;
    logic [PIX_W-1:0] b3;
  } pool_word_t;

endpackage

// File: verilog/cnn_ctrl_pkg.sv
package cnn_ctrl_pkg;

  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    LOAD  = 3'd1, // weight and tile fetch
    TILE  = 3'd2, // four conv positions through the pes
    WRITE = 3'd3, // two pooled words to temp ram
    DONE  = 3'd4
  } state_t;

  localparam int LOAD_LEN  = 51; // 50 reads plus one cycle of ram latency
  localparam int TILE_LEN  = 6;
  localparam int WRITE_LEN = 2;
  localparam int NUM_WIN   = 2;
  localparam int CNT_W     = $clog2(LOAD_LEN);

  // strobes from the fsm to the data path
  typedef struct packed {
    state_t phase;
    logic   win;   // pooling window index
    logic   clear; // rewind cache write pointers
    logic   sel;   // capture next 5x5 window
    logic   shift; // push pe results into the pool store
    logic   wr;    // temp ram write
  } ctrl_t;

endpackage

// File: verilog/cnn_ctrl_fsm.sv
`timescale 1ns/10ps
module cnn_ctrl_fsm (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           i_start,
  input  logic [cnn_ctrl_pkg::CNT_W-1:0] i_count,
  output cnn_ctrl_pkg::ctrl_t            o_ctrl,
  output logic                           o_done
);

  cnn_ctrl_pkg::state_t state;
  cnn_ctrl_pkg::state_t state_nxt;
  logic                 win;
  logic                 last_win;
  logic                 load_end;
  logic                 tile_end;
  logic                 write_end;

  assign load_end  = (int'(i_count) == cnn_ctrl_pkg::LOAD_LEN - 1);
  assign tile_end  = (int'(i_count) == cnn_ctrl_pkg::TILE_LEN - 1);
  assign write_end = (int'(i_count) == cnn_ctrl_pkg::WRITE_LEN - 1);
  assign last_win  = (int'(win) == cnn_ctrl_pkg::NUM_WIN - 1);

  always_comb begin
    state_nxt = state;
    case (state)
      cnn_ctrl_pkg::IDLE:  if (i_start) state_nxt = cnn_ctrl_pkg::LOAD;
      cnn_ctrl_pkg::LOAD:  if (load_end) state_nxt = cnn_ctrl_pkg::TILE;
      cnn_ctrl_pkg::TILE:  if (tile_end) state_nxt = cnn_ctrl_pkg::WRITE;
      cnn_ctrl_pkg::WRITE: begin
        if (write_end) state_nxt = last_win ? cnn_ctrl_pkg::DONE : cnn_ctrl_pkg::TILE;
      end
      default: state_nxt = cnn_ctrl_pkg::IDLE; // done lasts one cycle
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= cnn_ctrl_pkg::IDLE;
      win   <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == cnn_ctrl_pkg::IDLE) begin
        win <= 1'b0;
      end else if (state == cnn_ctrl_pkg::WRITE && write_end) begin
        win <= win + 1'b1; // next window after its words are out
      end
    end
  end

  // results reach the pool two cycles after their window is selected
  always_comb begin
    o_ctrl.phase = state;
    o_ctrl.win   = win;
    o_ctrl.clear = (state == cnn_ctrl_pkg::IDLE);
    o_ctrl.sel   = (state == cnn_ctrl_pkg::TILE) &&
                   (int'(i_count) < cnn_geom_pkg::POOL_POS);
    o_ctrl.shift = (state == cnn_ctrl_pkg::TILE) &&
                   (int'(i_count) >= cnn_ctrl_pkg::TILE_LEN - cnn_geom_pkg::POOL_POS);
    o_ctrl.wr    = (state == cnn_ctrl_pkg::WRITE);
  end

  assign o_done = (state == cnn_ctrl_pkg::DONE);

endmodule

// File: verilog/bram_addr_gen.sv
`timescale 1ns/10ps
module bram_addr_gen (
  input  logic                                clk,
  input  logic                                rst,
  input  cnn_ctrl_pkg::ctrl_t                 i_ctrl,
  output logic [cnn_ctrl_pkg::CNT_W-1:0]      o_count,
  output logic [cnn_geom_pkg::WORD_W-1:0]     o_if_addr,
  output logic                                o_if_en,
  output logic [cnn_geom_pkg::WORD_W-1:0]     o_w_addr,
  output logic                                o_w_en,
  output logic [cnn_geom_pkg::WORD_W-1:0]     o_temp_addr,
  output logic                                o_temp_en,
  output logic [cnn_geom_pkg::WORD_BYTES-1:0] o_temp_we,
  output logic                                o_if_wr,
  output logic                                o_w_wr
);

  int phase_last; // final count of the current phase

  always_comb begin
    case (i_ctrl.phase)
      cnn_ctrl_pkg::LOAD:  phase_last = cnn_ctrl_pkg::LOAD_LEN - 1;
      cnn_ctrl_pkg::TILE:  phase_last = cnn_ctrl_pkg::TILE_LEN - 1;
      cnn_ctrl_pkg::WRITE: phase_last = cnn_ctrl_pkg::WRITE_LEN - 1;
      default:             phase_last = 0; // idle and done hold at zero
    endcase
  end

  // wraps together with the fsm phase change
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_count <= '0;
    end else if (int'(o_count) == phase_last) begin
      o_count <= '0;
    end else begin
      o_count <= o_count + 1'b1;
    end
  end

  assign o_if_en = (i_ctrl.phase == cnn_ctrl_pkg::LOAD) &&
                   (int'(o_count) < cnn_geom_pkg::IF_WORDS);
  assign o_w_en  = (i_ctrl.phase == cnn_ctrl_pkg::LOAD) &&
                   (int'(o_count) < cnn_geom_pkg::W_WORDS);

  always_comb begin
    o_if_addr                           = '0;
    o_if_addr[cnn_ctrl_pkg::CNT_W-1:0]  = o_count;
    o_w_addr                            = '0;
    o_w_addr[cnn_ctrl_pkg::CNT_W-1:0]   = o_count;
    o_temp_addr                         = '0;
    o_temp_addr[1:0]                    = {i_ctrl.win, o_count[0]}; // two words per window
  end

  assign o_temp_en = i_ctrl.wr;
  assign o_temp_we = {cnn_geom_pkg::WORD_BYTES{i_ctrl.wr}};

  // read data shows up one cycle after the enable
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_if_wr <= 1'b0;
      o_w_wr  <= 1'b0;
    end else begin
      o_if_wr <= o_if_en;
      o_w_wr  <= o_w_en;
    end
  end

endmodule

// File: verilog/byte_cache.sv
`timescale 1ns/10ps
module byte_cache #(
  parameter int DEPTH = 48
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              i_clear,
  input  logic                              i_wr,
  input  logic [cnn_geom_pkg::WORD_W-1:0]   i_word,
  output logic [DEPTH*cnn_geom_pkg::PIX_W-1:0] o_bytes
);

  localparam int PTR_W = $clog2(DEPTH + 1);

  logic [cnn_geom_pkg::PIX_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]               wr_ptr; // byte index of the next word

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (i_clear) begin
      wr_ptr <= '0;
    end else if (i_wr) begin
      wr_ptr <= wr_ptr + PTR_W'(cnn_geom_pkg::WORD_BYTES);
    end
  end

  always_ff @(posedge clk) begin
    if (i_wr) begin
      for (int b = 0; b < cnn_geom_pkg::WORD_BYTES; b++) begin
        mem[int'(wr_ptr) + b] <= i_word[cnn_geom_pkg::WORD_W-1-b*cnn_geom_pkg::PIX_W -:
                                        cnn_geom_pkg::PIX_W]; // msb byte lands first
      end
    end
  end

  always_comb begin
    for (int k = 0; k < DEPTH; k++) begin
      o_bytes[k*cnn_geom_pkg::PIX_W +: cnn_geom_pkg::PIX_W] = mem[k];
    end
  end

endmodule

// File: verilog/window_select.sv
`timescale 1ns/10ps
module window_select (
  input  logic                  clk,
  input  logic                  rst,
  input  cnn_ctrl_pkg::ctrl_t   i_ctrl,
  input  logic [cnn_geom_pkg::TILE_ROWS*cnn_geom_pkg::TILE_COLS*cnn_geom_pkg::PIX_W-1:0] i_tile,
  output cnn_geom_pkg::window_t o_window
);

  logic [$clog2(cnn_geom_pkg::POOL_POS)-1:0] pos; // position inside the 2x2 pool
  int                                        offset;
  cnn_geom_pkg::window_t                     win_d;

  // wraps after the fourth select of each window
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pos <= '0;
    end else if (i_ctrl.sel) begin
      pos <= pos + 1'b1;
    end
  end

  always_comb begin
    // base + {0, 1, 8, 9}; window 1 starts two columns in
    offset = 2 * int'(i_ctrl.win) + int'(pos[0]) + cnn_geom_pkg::TILE_COLS * int'(pos[1]);
    for (int j = 0; j < cnn_geom_pkg::KSIZE; j++) begin
      for (int i = 0; i < cnn_geom_pkg::KSIZE; i++) begin
        win_d.pix[i + cnn_geom_pkg::KSIZE*j] =
          i_tile[(offset + i + cnn_geom_pkg::TILE_COLS*j)*cnn_geom_pkg::PIX_W +:
                 cnn_geom_pkg::PIX_W];
      end
    end
  end

  always_ff @(posedge clk) begin
    o_window <= i_ctrl.sel ? win_d : '0;
  end

endmodule

// File: verilog/pe_mac.sv
`timescale 1ns/10ps
module pe_mac (
  input  logic                           clk,
  input  logic                           rst,
  input  cnn_geom_pkg::window_t          i_window,
  input  cnn_geom_pkg::kernel_t          i_kernel,
  output logic [cnn_geom_pkg::PIX_W-1:0] o_result
);

  logic signed [cnn_geom_pkg::ACC_W-1:0] acc;
  logic signed [cnn_geom_pkg::ACC_W-1:0] scaled;
  logic        [cnn_geom_pkg::PIX_W-1:0] res_d;

  // unsigned pixel times signed weight, summed over 25 taps
  always_comb begin
    acc = '0;
    for (int k = 0; k < cnn_geom_pkg::KTAPS; k++) begin
      acc = acc + $signed({1'b0, i_window.pix[k]}) * $signed(i_kernel.w[k]);
    end
  end

  assign scaled = acc >>> cnn_geom_pkg::QUANT_SHIFT;

  always_comb begin
    if (acc[cnn_geom_pkg::ACC_W-1]) begin
      res_d = '0; // relu
    end else if (scaled > (2 ** cnn_geom_pkg::PIX_W - 1)) begin
      res_d = '1; // clip at 255
    end else begin
      res_d = scaled[cnn_geom_pkg::PIX_W-1:0];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_result <= '0;
    end else begin
      o_result <= res_d;
    end
  end

endmodule

// File: verilog/max_pool.sv
`timescale 1ns/10ps
module max_pool (
  input  logic                                              clk,
  input  logic                                              rst,
  input  cnn_ctrl_pkg::ctrl_t                               i_ctrl,
  input  logic [cnn_geom_pkg::NUM_PE-1:0][cnn_geom_pkg::PIX_W-1:0] i_results,
  output cnn_geom_pkg::pool_word_t                          o_temp_din
);

  // per channel, the last four conv results; newest in slot 0
  logic [cnn_geom_pkg::NUM_PE-1:0][cnn_geom_pkg::POOL_POS-1:0][cnn_geom_pkg::PIX_W-1:0] stage;
  logic [cnn_geom_pkg::NUM_PE-1:0][cnn_geom_pkg::PIX_W-1:0] ch_max;
  logic                                                     half; // upper channels

  always_ff @(posedge clk) begin
    if (i_ctrl.shift) begin
      for (int c = 0; c < cnn_geom_pkg::NUM_PE; c++) begin
        stage[c] <= {stage[c][cnn_geom_pkg::POOL_POS-2:0], i_results[c]};
      end
    end
  end

  always_comb begin
    for (int c = 0; c < cnn_geom_pkg::NUM_PE; c++) begin
      ch_max[c] = stage[c][0];
      for (int s = 1; s < cnn_geom_pkg::POOL_POS; s++) begin
        if (stage[c][s] > ch_max[c]) ch_max[c] = stage[c][s];
      end
    end
  end

  // first write cycle sends channels 0-3, second sends 4-7
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      half <= 1'b0;
    end else if (i_ctrl.wr) begin
      half <= ~half;
    end else begin
      half <= 1'b0;
    end
  end

  always_comb begin
    o_temp_din.b0 = ch_max[{half, 2'd0}];
    o_temp_din.b1 = ch_max[{half, 2'd1}];
    o_temp_din.b2 = ch_max[{half, 2'd2}];
    o_temp_din.b3 = ch_max[{half, 2'd3}];
  end

endmodule

// File: verilog/cnn_top.sv
`timescale 1ns/10ps
module cnn_top (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       i_start,
  input  logic [cnn_geom_pkg::WORD_W-1:0]            i_if_dout,
  input  logic [cnn_geom_pkg::WORD_W-1:0]            i_w_dout,
  output logic                                       o_done,
  output logic [cnn_geom_pkg::WORD_W-1:0]            o_if_addr,
  output logic                                       o_if_en,
  output logic [cnn_geom_pkg::WORD_W-1:0]            o_w_addr,
  output logic                                       o_w_en,
  output logic [cnn_geom_pkg::WORD_W-1:0]            o_temp_addr,
  output logic                                       o_temp_en,
  output logic [cnn_geom_pkg::WORD_BYTES-1:0]        o_temp_we,
  output cnn_geom_pkg::pool_word_t                   o_temp_din
);

  cnn_ctrl_pkg::ctrl_t                   ctrl;
  logic [cnn_ctrl_pkg::CNT_W-1:0]        count;
  logic                                  if_wr;
  logic                                  w_wr;
  logic [cnn_geom_pkg::TILE_ROWS*cnn_geom_pkg::TILE_COLS*cnn_geom_pkg::PIX_W-1:0] tile_bytes;
  logic [cnn_geom_pkg::NUM_PE*cnn_geom_pkg::KTAPS*cnn_geom_pkg::PIX_W-1:0]        w_bytes;
  cnn_geom_pkg::window_t                 window;
  logic [cnn_geom_pkg::NUM_PE-1:0][cnn_geom_pkg::PIX_W-1:0] results;

  cnn_ctrl_fsm u_fsm (
    .clk     (clk),
    .rst     (rst),
    .i_start (i_start),
    .i_count (count),
    .o_ctrl  (ctrl),
    .o_done  (o_done)
  );

  bram_addr_gen u_addr (
    .clk         (clk),
    .rst         (rst),
    .i_ctrl      (ctrl),
    .o_count     (count),
    .o_if_addr   (o_if_addr),
    .o_if_en     (o_if_en),
    .o_w_addr    (o_w_addr),
    .o_w_en      (o_w_en),
    .o_temp_addr (o_temp_addr),
    .o_temp_en   (o_temp_en),
    .o_temp_we   (o_temp_we),
    .o_if_wr     (if_wr),
    .o_w_wr      (w_wr)
  );

  // 6x8 input tile
  byte_cache #(.DEPTH(cnn_geom_pkg::TILE_ROWS * cnn_geom_pkg::TILE_COLS)) u_if_cache (
    .clk (clk), .rst (rst), .i_clear (ctrl.clear), .i_wr (if_wr),
    .i_word (i_if_dout), .o_bytes (tile_bytes)
  );

  // eight 5x5 kernels back to back
  byte_cache #(.DEPTH(cnn_geom_pkg::NUM_PE * cnn_geom_pkg::KTAPS)) u_w_cache (
    .clk (clk), .rst (rst), .i_clear (ctrl.clear), .i_wr (w_wr),
    .i_word (i_w_dout), .o_bytes (w_bytes)
  );

  window_select u_sel (
    .clk      (clk),
    .rst      (rst),
    .i_ctrl   (ctrl),
    .i_tile   (tile_bytes),
    .o_window (window)
  );

  for (genvar a = 0; a < cnn_geom_pkg::NUM_PE; a++) begin : g_pe
    cnn_geom_pkg::kernel_t kern;

    assign kern = w_bytes[a*cnn_geom_pkg::KTAPS*cnn_geom_pkg::PIX_W +:
                          cnn_geom_pkg::KTAPS*cnn_geom_pkg::PIX_W];

    pe_mac u_pe (
      .clk      (clk),
      .rst      (rst),
      .i_window (window), // same window feeds every channel
      .i_kernel (kern),
      .o_result (results[a])
    );
  end

  max_pool u_pool (
    .clk        (clk),
    .rst        (rst),
    .i_ctrl     (ctrl),
    .i_results  (results),
    .o_temp_din (o_temp_din)
  );

endmodule

// File: dv/tb_cnn_tasks.svh
// one new bit per lfsr step with taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_bits(input int n);
  logic [31:0] r;
  logic        fb;
  r = '0;
  for (int b = 0; b < n; b++) begin
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    r = {r[30:0], fb};
  end
  return r;
endfunction

// byte k of a ram with the high byte of each word first
function automatic int tile_pix(input int k);
  return int'(if_mem[k / 4][31 - 8 * (k % 4) -: 8]);
endfunction

function automatic int kern_w(input int k);
  logic [7:0] b;
  b = w_mem[k / 4][31 - 8 * (k % 4) -: 8];
  return int'($signed(b));
endfunction

task automatic build_expected();
  int off;
  int acc;
  int q;
  int mx;
  for (int win = 0; win < 2; win++) begin
    for (int ch = 0; ch < 8; ch++) begin
      mx = 0;
      for (int p = 0; p < 4; p++) begin
        off = 2 * win + p % 2 + 8 * (p / 2); // base, +1, +8, +9
        acc = 0;
        for (int j = 0; j < 5; j++) begin
          for (int i = 0; i < 5; i++) begin
            acc += tile_pix(off + i + 8 * j) * kern_w(25 * ch + 5 * j + i);
          end
        end
        q = (acc < 0) ? 0 : acc >> 2;
        if (q > 255) q = 255;
        if (q > mx) mx = q;
      end
      exp_mem[2 * win + ch / 4][31 - 8 * (ch % 4) -: 8] = 8'(mx);
    end
  end
endtask

task automatic fill_rams(input logic [31:0] if_word, input logic [31:0] w_word);
  foreach (if_mem[a]) if_mem[a] = if_word;
  foreach (w_mem[a]) w_mem[a] = w_word;
endtask

task automatic fill_random();
  foreach (if_mem[a]) if_mem[a] = lfsr_bits(32);
  foreach (w_mem[a]) w_mem[a] = lfsr_bits(32);
endtask

task automatic report_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
  n_errors++;
  $display("ERROR %s: got %h expected %h", sig, got, exp);
endtask

task automatic fail_plain(input string msg);
  n_errors++;
  $display("%s", msg);
endtask

// cycle c after start holds load count c - 1
task automatic check_port_timing(input int cyc);
  logic exp_if_en;
  logic exp_w_en;
  logic exp_temp;
  int   exp_temp_addr;
  exp_if_en     = (cyc >= 1) && (cyc <= 12);
  exp_w_en      = (cyc >= 1) && (cyc <= 50);
  exp_temp      = (cyc == 58) || (cyc == 59) || (cyc == 66) || (cyc == 67); // two per window
  exp_temp_addr = (cyc < 62) ? cyc - 58 : cyc - 64;
  n_checks += 3;
  if (o_if_en !== exp_if_en) report_value("o_if_en", 32'(o_if_en), 32'(exp_if_en));
  if (o_w_en !== exp_w_en) report_value("o_w_en", 32'(o_w_en), 32'(exp_w_en));
  if (o_temp_en !== exp_temp) report_value("o_temp_en", 32'(o_temp_en), 32'(exp_temp));
  if (exp_if_en && o_if_addr !== 32'(cyc - 1)) begin
    report_value("o_if_addr", o_if_addr, 32'(cyc - 1));
  end
  if (exp_w_en && o_w_addr !== 32'(cyc - 1)) begin
    report_value("o_w_addr", o_w_addr, 32'(cyc - 1));
  end
  if (exp_temp && o_temp_addr !== 32'(exp_temp_addr)) begin
    report_value("o_temp_addr", o_temp_addr, 32'(exp_temp_addr));
  end
endtask

// extra_at > 0 gives a second start pulse that many cycles in
task automatic run_conv(input int extra_at);
  int   cyc;
  int   hits0 [4];
  int   bad0;
  int   done0;
  logic seen;
  hits0 = hits;
  bad0  = bad_writes;
  done0 = done_cnt;
  seen  = 1'b0;
  cyc   = 0;
  @(posedge clk);
  i_start <= 1'b1;
  while (!seen && cyc < RUN_LIMIT) begin
    @(posedge clk);
    cyc++;
    i_start <= (cyc == extra_at);
    @(negedge clk);
    seen = (o_done === 1'b1);
    check_port_timing(cyc);
  end
  n_checks += 5;
  if (!seen) begin
    fail_plain($sformatf("o_done did not rise within %0d cycles of start", RUN_LIMIT));
  end else if (cyc != DONE_CYCLE) begin
    fail_plain($sformatf("o_done rose %0d cycles after start, expected %0d", cyc, DONE_CYCLE));
  end
  @(posedge clk);
  i_start <= 1'b0;
  @(negedge clk);
  if (o_done !== 1'b0) fail_plain("o_done stayed high for more than one cycle");
  if (done_cnt - done0 != 1) begin
    fail_plain($sformatf("saw %0d o_done pulses in one run, expected 1", done_cnt - done0));
  end
  for (int a = 0; a < 4; a++) begin
    if (hits[a] - hits0[a] != 1) begin
      fail_plain($sformatf("temp address %0d written %0d times, expected once",
                           a, hits[a] - hits0[a]));
    end
  end
  if (bad_writes != bad0) fail_plain("temp write outside 0 to 3 or with partial byte enables");
endtask

task automatic check_words();
  for (int a = 0; a < 4; a++) begin
    n_checks++;
    if (temp_mem[a] !== exp_mem[a]) begin
      report_value($sformatf("o_temp_din at temp address %0d", a), temp_mem[a], exp_mem[a]);
    end
  end
endtask

task automatic test_idle_after_reset();
  repeat (4) begin
    @(negedge clk);
    n_checks += 3;
    if (o_done !== 1'b0) report_value("o_done", 32'(o_done), 32'h0);
    if ({o_if_en, o_w_en, o_temp_en} !== 3'b000) begin
      report_value("o_if_en/o_w_en/o_temp_en", 32'({o_if_en, o_w_en, o_temp_en}), 32'h0);
    end
    if (o_temp_we !== 4'h0) report_value("o_temp_we", 32'(o_temp_we), 32'h0);
  end
endtask

task automatic test_all_ones();
  fill_rams(32'h01010101, 32'h01010101);
  run_conv(0);
  foreach (exp_mem[a]) exp_mem[a] = {4{8'(25 >> 2)}}; // 25 taps of 1*1
  check_words();
endtask

task automatic test_relu();
  fill_rams(32'h0, 32'hffffffff);  // every weight is -1
  foreach (if_mem[a]) if_mem[a] = 32'h01020304 * (a + 1); // pixels differ per word
  run_conv(0);
  foreach (exp_mem[a]) exp_mem[a] = 32'h0;
  check_words();
endtask

task automatic test_saturate();
  fill_rams(32'hffffffff, 32'h7f7f7f7f);
  run_conv(0);
  foreach (exp_mem[a]) exp_mem[a] = 32'hffffffff;
  check_words();
endtask

task automatic test_random();
  fill_random();
  build_expected();
  run_conv(0);
  check_words();
endtask

// stray start in LOAD, then a second run right after done
task automatic test_restart();
  fill_random();
  build_expected();
  run_conv(30);
  check_words();
  fill_random();
  build_expected();
  run_conv(0);
  check_words();
endtask

// File: dv/tb_cnn.sv
`timescale 1ns/10ps
module tb_cnn;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 5;
  localparam int NUM_TESTS  = 6;
  localparam int DONE_CYCLE = 68;  // start cycle to o_done
  localparam int RUN_LIMIT  = 150;

  logic        clk = 1'b0;
  logic        rst;
  logic        i_start;
  logic [31:0] i_if_dout = '0;
  logic [31:0] i_w_dout = '0;
  logic        o_done;
  logic [31:0] o_if_addr;
  logic        o_if_en;
  logic [31:0] o_w_addr;
  logic        o_w_en;
  logic [31:0] o_temp_addr;
  logic        o_temp_en;
  logic [3:0]  o_temp_we;
  logic [31:0] o_temp_din;

  logic [31:0] if_mem [12];
  logic [31:0] w_mem [50];
  logic [31:0] temp_mem [4];
  logic [31:0] exp_mem [4];   // model output per temp address
  int          hits [4] = '{default: 0};
  int          bad_writes = 0;
  int          done_cnt = 0;
  int          n_checks = 0;
  int          n_errors = 0;
  logic [31:0] lfsr_state = 32'h260d;

  cnn_top u_dut (
    .clk         (clk),
    .rst         (rst),
    .i_start     (i_start),
    .i_if_dout   (i_if_dout),
    .i_w_dout    (i_w_dout),
    .o_done      (o_done),
    .o_if_addr   (o_if_addr),
    .o_if_en     (o_if_en),
    .o_w_addr    (o_w_addr),
    .o_w_en      (o_w_en),
    .o_temp_addr (o_temp_addr),
    .o_temp_en   (o_temp_en),
    .o_temp_we   (o_temp_we),
    .o_temp_din  (o_temp_din)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // input and weight rams, data one clock after the address
  always @(posedge clk) begin
    if (o_if_en) i_if_dout <= if_mem[o_if_addr[3:0]];
    if (o_w_en) i_w_dout <= w_mem[o_w_addr[5:0]];
  end

  // temp ram keeps a hit count per address
  always @(posedge clk) begin
    if (o_temp_en && o_temp_we != 4'h0) begin
      if (o_temp_addr < 4 && o_temp_we == 4'hf) begin
        temp_mem[o_temp_addr[1:0]] <= o_temp_din;
        hits[o_temp_addr[1:0]]++;
      end else begin
        bad_writes++;
      end
    end
  end

  always @(posedge clk) begin
    if (o_done === 1'b1) done_cnt++;
  end

  `include "tb_cnn_tasks.svh"

  initial begin
    rst     = 1'b1;
    i_start = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    test_idle_after_reset();
    test_all_ones();
    test_relu();
    test_saturate();
    test_random();
    test_restart();
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // generous bound, a full run takes about 70 cycles
  initial begin
    #(NUM_TESTS * 100 * CLK_PERIOD);
    $display("timeout after %0d cycles, checks %0d, errors %0d",
             NUM_TESTS * 100, n_checks, n_errors);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: compile.f
verilog/cnn_geom_pkg.sv
verilog/cnn_ctrl_pkg.sv
verilog/cnn_ctrl_fsm.sv
verilog/bram_addr_gen.sv
verilog/byte_cache.sv
verilog/window_select.sv
verilog/pe_mac.sv
verilog/max_pool.sv
verilog/cnn_top.sv
+incdir+dv
dv/tb_cnn.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cnn
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary -Wno-fatal
PASS_MSG  ?= Verification passed

SRCS := $(shell grep -v '^+' $(FILELIST)) dv/tb_cnn_tasks.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
